//--- common/music_pkg.sv
`default_nettype none

package music_pkg;

  // datapath widths
  typedef logic [9:0]  freq_t;      // pitch in hertz, 0 is a rest
  typedef logic [3:0]  beats_t;     // note length in beats
  typedef logic [4:0]  note_idx_t;  // position inside a section
  typedef logic [2:0]  part_t;      // part number 1..NUM_PARTS
  typedef logic [11:0] millis_t;    // ms count of a play or gap phase
  typedef logic [15:0] tick_cfg_t;  // clock cycles per millisecond
  typedef logic [31:0] acc_t;       // tone accumulator
  typedef logic [6:0]  segments_t;  // bit 0 top bar, bit 6 middle bar

  typedef enum logic {
    SECTION_INTRO  = 1'b0,
    SECTION_CHORUS = 1'b1
  } section_t;

  // one entry of the note table
  typedef struct packed {
    freq_t  freq;
    beats_t beats;
  } note_t;

  // timing
  localparam int BEAT_MS           = 100;   // tempo
  localparam int MILLIS_PER_SECOND = 1000;
  localparam int GAP_DIVISOR       = 3;     // gap is a third of the note

  // arrangement: intro, intro, chorus, chorus
  localparam int NUM_PARTS   = 4;
  localparam int INTRO_PARTS = 2;   // parts 1..INTRO_PARTS play the intro

  // last index of each section
  localparam int INTRO_LAST  = 12;
  localparam int CHORUS_LAST = 15;  // first phrase of the chorus only

endpackage

`default_nettype wire

//--- song/song_rom.sv
`timescale 1ns/1ps
`default_nettype none

module song_rom (
  input  wire music_pkg::section_t  section,
  input  wire music_pkg::note_idx_t note_index,
  output music_pkg::freq_t          note_freq,
  output music_pkg::beats_t         note_beats,
  output logic                      last_note
);

  music_pkg::note_t intro_note;
  music_pkg::note_t chorus_note;
  music_pkg::note_t sel_note;

  // intro, pitch and beats
  always_comb begin
    case (note_index)
      5'd0:    intro_note = {10'd554, 4'd6};   // c5s
      5'd1:    intro_note = {10'd622, 4'd10};  // e5f
      5'd2:    intro_note = {10'd622, 4'd6};   // e5f
      5'd3:    intro_note = {10'd698, 4'd6};   // f5
      5'd4:    intro_note = {10'd831, 4'd1};   // a5f
      5'd5:    intro_note = {10'd740, 4'd1};   // f5s
      5'd6:    intro_note = {10'd698, 4'd1};   // f5
      5'd7:    intro_note = {10'd622, 4'd1};   // e5f
      5'd8:    intro_note = {10'd554, 4'd6};   // c5s
      5'd9:    intro_note = {10'd622, 4'd10};  // e5f
      5'd10:   intro_note = {10'd0,   4'd4};   // rest
      5'd11:   intro_note = {10'd415, 4'd2};   // a4f
      5'd12:   intro_note = {10'd415, 4'd10};  // a4f
      default: intro_note = '0;
    endcase
  end

  // chorus, first phrase
  always_comb begin
    case (note_index)
      5'd0:    chorus_note = {10'd466, 4'd1};  // b4f
      5'd1:    chorus_note = {10'd466, 4'd1};  // b4f
      5'd2:    chorus_note = {10'd415, 4'd1};  // a4f
      5'd3:    chorus_note = {10'd415, 4'd1};  // a4f
      5'd4:    chorus_note = {10'd698, 4'd3};  // f5
      5'd5:    chorus_note = {10'd698, 4'd3};  // f5
      5'd6:    chorus_note = {10'd622, 4'd6};  // e5f
      5'd7:    chorus_note = {10'd466, 4'd1};  // b4f
      5'd8:    chorus_note = {10'd466, 4'd1};  // b4f
      5'd9:    chorus_note = {10'd415, 4'd1};  // a4f
      5'd10:   chorus_note = {10'd415, 4'd1};  // a4f
      5'd11:   chorus_note = {10'd622, 4'd3};  // e5f
      5'd12:   chorus_note = {10'd622, 4'd3};  // e5f
      5'd13:   chorus_note = {10'd554, 4'd3};  // c5s
      5'd14:   chorus_note = {10'd523, 4'd1};  // c5
      5'd15:   chorus_note = {10'd466, 4'd2};  // b4f
      default: chorus_note = '0;
    endcase
  end

  always_comb begin
    if (section == music_pkg::SECTION_CHORUS) begin
      sel_note  = chorus_note;
      last_note = (note_index == music_pkg::note_idx_t'(music_pkg::CHORUS_LAST));
    end else begin
      sel_note  = intro_note;
      last_note = (note_index == music_pkg::note_idx_t'(music_pkg::INTRO_LAST));
    end
  end

  assign note_freq  = sel_note.freq;
  assign note_beats = sel_note.beats;

endmodule

`default_nettype wire

//--- song/note_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module note_sequencer (
  input  wire                        clk,
  input  wire                        rst,
  input  wire music_pkg::tick_cfg_t  ticks_per_milli,
  input  wire music_pkg::freq_t      note_freq,
  input  wire music_pkg::beats_t     note_beats,
  input  wire                        last_note,
  output music_pkg::section_t        section,
  output music_pkg::note_idx_t       note_index,
  output music_pkg::freq_t           tone_freq,
  output music_pkg::part_t           part,
  output logic                       note_on
);

  typedef enum logic [1:0] {
    PH_FETCH,
    PH_PLAY,
    PH_GAP
  } phase_t;

  phase_t               phase;
  music_pkg::tick_cfg_t tick_cnt;
  music_pkg::millis_t   ms_cnt;
  music_pkg::millis_t   play_ms;   // length of the current note
  music_pkg::millis_t   gap_ms;
  music_pkg::millis_t   fetch_ms;
  music_pkg::part_t     next_part;
  logic                 milli_tick;

  // one tick in every ticks_per_milli cycles
  assign milli_tick = (tick_cnt == ticks_per_milli - music_pkg::tick_cfg_t'(1));

  assign fetch_ms = music_pkg::millis_t'(note_beats) *
                    music_pkg::millis_t'(music_pkg::BEAT_MS);
  assign gap_ms   = play_ms / music_pkg::millis_t'(music_pkg::GAP_DIVISOR);

  assign next_part = (part == music_pkg::part_t'(music_pkg::NUM_PARTS)) ?
                     music_pkg::part_t'(1) : part + music_pkg::part_t'(1);

  assign section = (part > music_pkg::part_t'(music_pkg::INTRO_PARTS)) ?
                   music_pkg::SECTION_CHORUS : music_pkg::SECTION_INTRO;

  assign note_on = (tone_freq != '0);  // rests keep the dot dark

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= PH_FETCH;
      tick_cnt   <= '0;
      ms_cnt     <= '0;
      tone_freq  <= '0;
      part       <= music_pkg::part_t'(1);
      note_index <= '0;
    end else begin
      // timebase restarts at every fetch
      if (phase == PH_FETCH || milli_tick) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + music_pkg::tick_cfg_t'(1);
      end

      case (phase)
        PH_FETCH: begin
          tone_freq <= note_freq;
          ms_cnt    <= '0;
          phase     <= PH_PLAY;
          if (last_note) begin
            part       <= next_part;  // wraps after the last part
            note_index <= '0;
          end else begin
            note_index <= note_index + music_pkg::note_idx_t'(1);
          end
        end

        PH_PLAY: begin
          if (milli_tick) begin
            if (ms_cnt == play_ms - music_pkg::millis_t'(1)) begin
              ms_cnt    <= '0;
              tone_freq <= '0;      // silence for the gap
              phase     <= PH_GAP;
            end else begin
              ms_cnt <= ms_cnt + music_pkg::millis_t'(1);
            end
          end
        end

        PH_GAP: begin
          if (milli_tick) begin
            if (ms_cnt == gap_ms - music_pkg::millis_t'(1)) begin
              ms_cnt <= '0;
              phase  <= PH_FETCH;
            end else begin
              ms_cnt <= ms_cnt + music_pkg::millis_t'(1);
            end
          end
        end

        default: phase <= PH_FETCH;
      endcase
    end
  end

  // note length, captured with the table outputs
  always_ff @(posedge clk) begin
    if (phase == PH_FETCH) begin
      play_ms <= fetch_ms;
    end
  end

endmodule

`default_nettype wire

//--- hw/tone_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tone_generator (
  input  wire                        clk,
  input  wire                        rst,
  input  wire music_pkg::tick_cfg_t  ticks_per_milli,
  input  wire music_pkg::freq_t      tone_freq,
  output logic                       sound
);

  music_pkg::acc_t ticks_per_second;
  music_pkg::acc_t half_period;  // toggle threshold
  music_pkg::acc_t acc;
  music_pkg::acc_t acc_step;

  assign ticks_per_second = music_pkg::acc_t'(ticks_per_milli) *
                            music_pkg::acc_t'(music_pkg::MILLIS_PER_SECOND);
  assign half_period      = ticks_per_second >> 1;
  assign acc_step         = acc + music_pkg::acc_t'(tone_freq);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (tone_freq == '0) begin
      acc   <= '0;    // fresh phase for the next note
      sound <= 1'b0;
    end else if (acc >= half_period) begin
      sound <= ~sound;
      acc   <= acc_step - half_period;
    end else begin
      acc <= acc_step;
    end
  end

endmodule

`default_nettype wire

//--- hw/part_display.sv
`timescale 1ns/1ps
`default_nettype none

module part_display (
  input  wire music_pkg::part_t part,
  input  wire                   note_on,
  output logic [7:0]            led
);

  music_pkg::segments_t segments;
  logic [3:0]           digit;

  assign digit = {1'b0, part};

  /*
   * segment order, bit 0 on top and going clockwise
   *      0
   *    5   1
   *      6
   *    4   2
   *      3
   */
  always_comb begin
    case (digit)
      4'd0:    segments = 7'b0111111;
      4'd1:    segments = 7'b0000110;
      4'd2:    segments = 7'b1011011;
      4'd3:    segments = 7'b1001111;
      4'd4:    segments = 7'b1100110;
      4'd5:    segments = 7'b1101101;
      4'd6:    segments = 7'b1111100;  // no top bar
      4'd7:    segments = 7'b0000111;
      4'd8:    segments = 7'b1111111;
      4'd9:    segments = 7'b1100111;
      default: segments = 7'b0000000;  // blank
    endcase
  end

  assign led[6:0] = segments;
  assign led[7]   = note_on;  // dot while a note sounds

endmodule

`default_nettype wire

//--- hw/music_player.sv
`timescale 1ns/1ps
`default_nettype none

module music_player (
  input  wire                        clk,
  input  wire                        rst,
  input  wire music_pkg::tick_cfg_t  ticks_per_milli,
  output logic [7:0]                 led,
  output logic                       sound
);

  music_pkg::section_t  section;
  music_pkg::note_idx_t note_index;
  music_pkg::freq_t     note_freq;
  music_pkg::beats_t    note_beats;
  logic                 last_note;
  music_pkg::freq_t     tone_freq;
  music_pkg::part_t     part;
  logic                 note_on;

  note_sequencer u_note_sequencer (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .note_freq       (note_freq),
    .note_beats      (note_beats),
    .last_note       (last_note),
    .section         (section),
    .note_index      (note_index),
    .tone_freq       (tone_freq),
    .part            (part),
    .note_on         (note_on)
  );

  song_rom u_song_rom (
    .section    (section),
    .note_index (note_index),
    .note_freq  (note_freq),
    .note_beats (note_beats),
    .last_note  (last_note)
  );

  tone_generator u_tone_generator (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .tone_freq       (tone_freq),
    .sound           (sound)
  );

  part_display u_part_display (
    .part    (part),
    .note_on (note_on),
    .led     (led)
  );

endmodule

`default_nettype wire

//--- verif/tb_music_player.sv
`timescale 1ns/1ps
`default_nettype none

module tb_music_player;

  localparam int MAX_CYCLES = 90000;  // 1.2 passes at 2 cycles/ms plus a short run at 3
  localparam int RUN1_NOTES = 71;     // 58 notes per pass, well into the second pass
  localparam int RUN2_NOTES = 7;

  localparam int PH_FETCH = 0;
  localparam int PH_PLAY  = 1;
  localparam int PH_GAP   = 2;

  localparam int INTRO_LEN  = 13;
  localparam int CHORUS_LEN = 16;

  localparam int INTRO_FREQ [INTRO_LEN] =
    '{554, 622, 622, 698, 831, 740, 698, 622, 554, 622, 0, 415, 415};
  localparam int INTRO_BEATS [INTRO_LEN] =
    '{6, 10, 6, 6, 1, 1, 1, 1, 6, 10, 4, 2, 10};
  localparam int CHORUS_FREQ [CHORUS_LEN] =
    '{466, 466, 415, 415, 698, 698, 622, 466, 466, 415, 415, 622, 622, 554, 523, 466};
  localparam int CHORUS_BEATS [CHORUS_LEN] =
    '{1, 1, 1, 1, 3, 3, 6, 1, 1, 1, 1, 3, 3, 3, 1, 2};

  logic                 clk;
  logic                 rst;
  music_pkg::tick_cfg_t ticks_per_milli;
  logic [7:0]           led;
  logic                 sound;

  int seed = 32'hbfdad17d;  // stimulus is fully deterministic

  // expected note schedule
  int   m_phase;
  int   m_left;             // cycles left in play or gap
  int   m_part;
  int   m_idx;
  int   cur_freq;
  int   cur_play_ms;
  int   exp_edges;
  int   edge_cnt;
  int   notes_done      = 0;
  int   cycle_cnt       = 0;
  logic prev_rst        = 1'b0;
  logic prev_dot        = 1'b0;
  logic prev_sound      = 1'b0;

  music_player u_dut (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .led             (led),
    .sound           (sound)
  );

  task automatic stop_on_error(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "first error, run stopped");
  endtask

  function automatic logic [6:0] digit_segments(input int d);
    case (d)
      1:       digit_segments = 7'b0000110;
      2:       digit_segments = 7'b1011011;
      3:       digit_segments = 7'b1001111;
      4:       digit_segments = 7'b1100110;
      default: digit_segments = 7'b0000000;
    endcase
  endfunction

  function automatic int pitch_at(input int part, input int idx);
    if (part <= music_pkg::INTRO_PARTS) begin
      return INTRO_FREQ[idx[3:0]];
    end
    return CHORUS_FREQ[idx[3:0]];
  endfunction

  function automatic int beats_at(input int part, input int idx);
    if (part <= music_pkg::INTRO_PARTS) begin
      return INTRO_BEATS[idx[3:0]];
    end
    return CHORUS_BEATS[idx[3:0]];
  endfunction

  function automatic int section_length(input int part);
    return (part <= music_pkg::INTRO_PARTS) ? INTRO_LEN : CHORUS_LEN;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // outputs are sampled on the rising edge, before they update
  always @(posedge clk) begin
    if (rst) begin
      if (prev_rst) begin
        assert (sound == 1'b0) else stop_on_error("sound high during reset");
        assert (led[7] == 1'b0) else stop_on_error("dot lit during reset");
        assert (led[6:0] == digit_segments(1)) else stop_on_error("display not 1 in reset");
      end
      m_phase     = PH_FETCH;
      m_part      = 1;
      m_idx       = 0;
      cur_freq    = 0;
      cur_play_ms = 0;
      edge_cnt    = 0;
      notes_done  = 0;
      prev_dot    = 1'b0;
      prev_sound  = 1'b0;
    end else begin
      // sound follows the pitch one clock later
      if (!prev_dot) begin
        assert (sound == 1'b0) else stop_on_error("sound not silent outside a note");
      end
      if (prev_dot && sound && !prev_sound) begin
        edge_cnt++;
      end
      case (m_phase)
        PH_FETCH: begin
          assert (led[7] == 1'b0) else stop_on_error("dot lit during note fetch");
          assert (led[6:0] == digit_segments(m_part))
            else stop_on_error($sformatf("display %b, expected part %0d", led[6:0], m_part));
          if (cur_freq != 0) begin
            exp_edges = cur_freq * cur_play_ms / music_pkg::MILLIS_PER_SECOND;
            assert (edge_cnt >= exp_edges - 1 && edge_cnt <= exp_edges + 1)
              else stop_on_error($sformatf("%0d sound edges for %0d Hz, expected %0d",
                                           edge_cnt, cur_freq, exp_edges));
          end
          cur_freq    = pitch_at(m_part, m_idx);
          cur_play_ms = beats_at(m_part, m_idx) * music_pkg::BEAT_MS;
          edge_cnt = 0;
          m_left   = cur_play_ms * int'(ticks_per_milli);
          m_phase  = PH_PLAY;
          notes_done++;
          if (m_idx == section_length(m_part) - 1) begin
            m_idx  = 0;
            m_part = (m_part == music_pkg::NUM_PARTS) ? 1 : m_part + 1;
          end else begin
            m_idx++;
          end
        end
        PH_PLAY: begin
          assert (led[7] == (cur_freq != 0))
            else stop_on_error($sformatf("dot wrong during play of %0d Hz", cur_freq));
          m_left--;
          if (m_left == 0) begin
            m_left  = (cur_play_ms / music_pkg::GAP_DIVISOR) * int'(ticks_per_milli);
            m_phase = PH_GAP;
          end
        end
        default: begin
          assert (led[7] == 1'b0) else stop_on_error("dot lit during gap");
          m_left--;
          if (m_left == 0) begin
            m_phase = PH_FETCH;
          end
        end
      endcase
      prev_dot   = led[7];
      prev_sound = sound;
    end
    prev_rst = rst;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  task automatic reset_dut();
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  endtask

  initial begin
    rst             = 1'b1;
    ticks_per_milli = music_pkg::tick_cfg_t'(2);  // 2 cycles per ms
    reset_dut();
    while (notes_done < RUN1_NOTES) begin
      @(negedge clk);
    end

    // second run on a slower timebase
    @(negedge clk);
    ticks_per_milli = music_pkg::tick_cfg_t'(3);
    reset_dut();
    while (notes_done < RUN2_NOTES) begin
      @(negedge clk);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
common/music_pkg.sv
song/song_rom.sv
song/note_sequencer.sv
hw/tone_generator.sv
hw/part_display.sv
hw/music_player.sv
verif/tb_music_player.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the music player testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_music_player
BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -f files.f --top-module "$TOP" --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation finished, log in $LOG"
exit 0
